//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := uart_core_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv tests/*.sv include/*.svh)
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
source/miner_io_pkg.sv
source/uart_receiver.sv
source/uart_transmitter.sv
source/header_collector.sv
source/nonce_sender.sv
source/hex_display.sv
source/uart_core.sv
tests/uart_core_props.sv
tests/uart_core_tb.sv

//--- include/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// ############################################################
// serial timing
// ############################################################

// clock cycles per serial bit, 8N1 framing
`define UART_CLKS_PER_BIT 16

// ############################################################
// message sizes
// ############################################################

`define UART_HEADER_BYTES 80 // block header, msb first
`define UART_NONCE_BYTES 4   // nonce reply, msb first

// ############################################################
// display
// ############################################################

// cycles each digit stays lit
`define UART_SCAN_DIV 8

`endif

//--- source/header_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module header_collector (
    input  logic                             clock,
    input  logic                             reset,
    input  miner_io_pkg::rx_byte_t           rx_in,
    output logic                             header_req,
    input  logic                             header_ack,
    output logic [`UART_HEADER_BYTES*8-1:0]  header_data
);
    localparam int HDR_W = `UART_HEADER_BYTES * 8;
    localparam int CNT_W = $clog2(`UART_HEADER_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`UART_HEADER_BYTES - 1);

    logic [CNT_W-1:0] byte_cnt;
    logic             ack_wait; // req dropped, ack still high

    always_ff @(posedge clock) begin
        if (reset) begin
            header_req  <= 1'b0;
            ack_wait    <= 1'b0;
            byte_cnt    <= '0;
            header_data <= '0;
        end else if (header_req) begin
            // header held stable, incoming bytes ignored
            if (header_ack) begin
                header_req <= 1'b0;
                ack_wait   <= 1'b1;
            end
        end else if (ack_wait) begin
            if (!header_ack)
                ack_wait <= 1'b0;
        end else if (rx_in.valid) begin
            // first byte ends up on top
            header_data <= {header_data[HDR_W-9:0], rx_in.data};
            if (byte_cnt == LAST_BYTE) begin
                byte_cnt   <= '0;
                header_req <= 1'b1;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module hex_display (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] value,
    output logic [7:0]  ca,
    output logic [7:0]  an
);
    localparam int DIV_W = (`UART_SCAN_DIV > 1) ? $clog2(`UART_SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_SCAN_DIV - 1);

    logic [DIV_W-1:0] div;
    logic [2:0]       digit;
    logic             step;

    // active low gfedcba
    function automatic logic [6:0] glyph(input logic [3:0] nib);
        case (nib)
            4'h0: glyph = 7'b1000000;
            4'h1: glyph = 7'b1111001;
            4'h2: glyph = 7'b0100100;
            4'h3: glyph = 7'b0110000;
            4'h4: glyph = 7'b0011001;
            4'h5: glyph = 7'b0010010;
            4'h6: glyph = 7'b0000010;
            4'h7: glyph = 7'b1111000;
            4'h8: glyph = 7'b0000000;
            4'h9: glyph = 7'b0010000;
            4'ha: glyph = 7'b0001000;
            4'hb: glyph = 7'b0000011;
            4'hc: glyph = 7'b1000110;
            4'hd: glyph = 7'b0100001;
            4'he: glyph = 7'b0000110;
            default: glyph = 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            div   <= '0;
            digit <= 3'd7; // first step lands on digit 0
            step  <= 1'b0;
            an    <= '1;
            ca    <= '1;
        end else begin
            step <= 1'b0;
            if (div == DIV_LAST) begin
                div   <= '0;
                digit <= digit + 1'b1;
                step  <= 1'b1;
            end else begin
                div <= div + 1'b1;
            end
            if (step) begin
                an <= ~(8'b1 << digit);
                ca <= {1'b1, glyph(value[{digit, 2'b00} +: 4])}; // dp off
            end
        end
    end

endmodule

`default_nettype wire

//--- source/miner_io_pkg.sv
`default_nettype none

package miner_io_pkg;

    // ############################################################
    // fsm states
    // ############################################################

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef enum logic [2:0] {
        ns_idle,
        ns_load,
        ns_send,
        ns_wait_tx,
        ns_ack
    } send_state_t;

    // ############################################################
    // byte streams
    // ############################################################

    // receiver output, held one cycle
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       frame_error; // stop bit sampled low
    } rx_byte_t;

    // request to the transmitter
    typedef struct packed {
        logic       start;
        logic [7:0] data;
    } tx_byte_t;

endpackage

`default_nettype wire

//--- source/nonce_sender.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module nonce_sender (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   nonce_req,
    output logic                   nonce_ack,
    input  logic [31:0]            nonce_data,
    input  logic                   busy,
    output miner_io_pkg::tx_byte_t tx_out,
    output logic [31:0]            nonce_shown
);
    import miner_io_pkg::*;

    localparam int CNT_W = $clog2(`UART_NONCE_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`UART_NONCE_BYTES - 1);

    send_state_t      state;
    logic [CNT_W-1:0] byte_cnt;
    logic             busy_q;
    logic [31:0]      shift_q;

    // ############################################################
    // sequencing
    // ############################################################

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ns_idle;
            byte_cnt    <= '0;
            busy_q      <= 1'b0;
            tx_out      <= '0;
            nonce_shown <= '0;
        end else begin
            busy_q       <= busy;
            tx_out.start <= 1'b0;
            case (state)
                ns_idle: begin
                    if (nonce_req)
                        state <= ns_load;
                end
                ns_load: begin
                    nonce_shown <= nonce_data; // kept for the display
                    byte_cnt    <= '0;
                    state       <= ns_send;
                end
                ns_send: begin
                    if (!busy) begin
                        tx_out.start <= 1'b1;
                        tx_out.data  <= shift_q[31:24];
                        state        <= ns_wait_tx;
                    end
                end
                ns_wait_tx: begin
                    // falling edge of busy ends the frame
                    if (busy_q && !busy) begin
                        if (byte_cnt == LAST_BYTE) begin
                            state <= ns_ack;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= ns_send;
                        end
                    end
                end
                ns_ack: begin
                    if (!nonce_req)
                        state <= ns_idle;
                end
                default: state <= ns_idle;
            endcase
        end
    end

    // top byte goes out first
    always_ff @(posedge clock) begin
        if (state == ns_load)
            shift_q <= nonce_data;
        else if (state == ns_send && !busy)
            shift_q <= {shift_q[23:0], 8'h00};
    end

    assign nonce_ack = (state == ns_ack);

endmodule

`default_nettype wire

//--- source/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_core (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             rxd,
    output logic                             txd,
    output logic                             header_req,
    input  logic                             header_ack,
    output logic [`UART_HEADER_BYTES*8-1:0]  header_data,
    input  logic                             nonce_req,
    output logic                             nonce_ack,
    input  logic [31:0]                      nonce_data,
    input  logic                             display_toggle,
    output logic [7:0]                       ca,
    output logic [7:0]                       an,
    output logic                             error
);
    import miner_io_pkg::*;

    localparam int HDR_W = `UART_HEADER_BYTES * 8;

    rx_byte_t    rx_byte;
    tx_byte_t    tx_byte;
    logic        tx_busy;
    logic [31:0] nonce_shown;
    logic [31:0] display_word;

    // ############################################################
    // receive path
    // ############################################################

    uart_receiver u_receiver (
        .clock  (clock),
        .reset  (reset),
        .rxd    (rxd),
        .rx_out (rx_byte)
    );

    header_collector u_collector (
        .clock       (clock),
        .reset       (reset),
        .rx_in       (rx_byte),
        .header_req  (header_req),
        .header_ack  (header_ack),
        .header_data (header_data)
    );

    // sticky until reset
    always_ff @(posedge clock) begin
        if (reset)
            error <= 1'b0;
        else if (rx_byte.frame_error)
            error <= 1'b1;
    end

    // ############################################################
    // transmit path
    // ############################################################

    nonce_sender u_sender (
        .clock       (clock),
        .reset       (reset),
        .nonce_req   (nonce_req),
        .nonce_ack   (nonce_ack),
        .nonce_data  (nonce_data),
        .busy        (tx_busy),
        .tx_out      (tx_byte),
        .nonce_shown (nonce_shown)
    );

    uart_transmitter u_transmitter (
        .clock (clock),
        .reset (reset),
        .tx_in (tx_byte),
        .txd   (txd),
        .busy  (tx_busy)
    );

    assign display_word = display_toggle ? header_data[HDR_W-1 -: 32] : nonce_shown;

    hex_display u_display (
        .clock (clock),
        .reset (reset),
        .value (display_word),
        .ca    (ca),
        .an    (an)
    );

endmodule

`default_nettype wire

//--- source/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_receiver (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   rxd,
    output miner_io_pkg::rx_byte_t rx_out
);
    import miner_io_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_CLKS_PER_BIT - 1);

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    // two flop synchronizer, line idles high
    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= rx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            rx_out  <= '0;
        end else begin
            rx_out <= '0; // one cycle pulse
            cnt    <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rxd_sync)
                        state <= rx_start;
                end
                rx_start: begin
                    if (cnt == HALF_BIT) begin // middle of start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (cnt == FULL_BIT) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (cnt == FULL_BIT) begin
                        state <= rx_idle;
                        if (rxd_sync) begin
                            rx_out.valid <= 1'b1;
                            rx_out.data  <= shift_q;
                        end else begin
                            rx_out.frame_error <= 1'b1; // byte dropped
                        end
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clock) begin
        if (state == rx_data && cnt == FULL_BIT)
            shift_q <= {rxd_sync, shift_q[7:1]};
    end

endmodule

`default_nettype wire

//--- source/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_transmitter (
    input  logic                   clock,
    input  logic                   reset,
    input  miner_io_pkg::tx_byte_t tx_in,
    output logic                   txd,
    output logic                   busy
);
    import miner_io_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_CLKS_PER_BIT - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= tx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
            busy    <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                tx_idle: begin
                    cnt <= '0;
                    if (tx_in.start) begin
                        state <= tx_start;
                        txd   <= 1'b0; // start bit
                        busy  <= 1'b1;
                    end
                end
                tx_start: begin
                    if (cnt == FULL_BIT) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        txd     <= shift_q[0];
                        state   <= tx_data;
                    end
                end
                tx_data: begin
                    if (cnt == FULL_BIT) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1; // stop bit
                            state <= tx_stop;
                        end else begin
                            txd <= shift_q[1]; // next bit, shifted this edge
                        end
                    end
                end
                tx_stop: begin
                    if (cnt == FULL_BIT) begin
                        busy  <= 1'b0;
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == tx_idle && tx_in.start)
            shift_q <= tx_in.data;
        else if (state == tx_data && cnt == FULL_BIT)
            shift_q <= {1'b0, shift_q[7:1]};
    end

endmodule

`default_nettype wire

//--- tests/uart_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core_props (
    input logic       clock,
    input logic       reset,
    input logic       header_req,
    input logic       header_ack,
    input logic       nonce_req,
    input logic       nonce_ack,
    input logic [7:0] an,
    input logic       txd,
    input logic       busy
);

    int fail_count = 0;

    // requester holds until the ack arrives
    hold_req: assert property (@(posedge clock) disable iff (reset)
        header_req && !header_ack |=> header_req)
        else begin
            $error("header_req dropped before header_ack was seen");
            fail_count++;
        end

    ack_in_req: assert property (@(posedge clock) disable iff (reset)
        $rose(nonce_ack) |-> nonce_req)
        else begin
            $error("nonce_ack rose while nonce_req was low");
            fail_count++;
        end

    one_digit: assert property (@(posedge clock) disable iff (reset)
        an == 8'hff || $onehot(~an))
        else begin
            $error("more than one digit enabled on an");
            fail_count++;
        end

    idle_line: assert property (@(posedge clock) disable iff (reset)
        !busy |-> txd) // line idles high
        else begin
            $error("txd low while the transmitter is idle");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- tests/uart_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_core_tb;

    localparam int HDR_BYTES   = `UART_HEADER_BYTES;
    localparam int HDR_W       = `UART_HEADER_BYTES * 8;
    localparam int NONCE_BYTES = `UART_NONCE_BYTES;
    localparam int BIT_CLKS    = `UART_CLKS_PER_BIT;
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;
    // three headers, two nonces, the bad frame and its idle bit
    localparam int FRAMES      = 3 * HDR_BYTES + 2 * NONCE_BYTES + 2;
    localparam int WATCHDOG_NS = FRAMES * (FRAME_CLKS + 24) * 10 * 2 + 20000;

    // active low gfedcba glyphs, 0 to f
    localparam logic [6:0] SEG [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic             clock;
    logic             reset;
    logic             rxd;
    logic             txd;
    logic             header_req;
    logic             header_ack;
    logic [HDR_W-1:0] header_data;
    logic             nonce_req;
    logic             nonce_ack;
    logic [31:0]      nonce_data;
    logic             display_toggle;
    logic [7:0]       ca;
    logic [7:0]       an;
    logic             error;

    // ############################################################
    // reference model
    // ############################################################

    logic [7:0]  hdr_bytes [HDR_BYTES];
    logic [31:0] exp_nonce_shown = '0;
    logic        exp_error = 1'b0;
    logic [7:0]  tx_queue [$];
    logic [7:0]  mon_byte;

    int seed = 85794;
    int value_errors = 0;
    int other_errors = 0;
    int stop_errors = 0; // counted by the txd monitor
    int prop_errors = 0; // failures in the bound checker

    uart_core DUT (
        .clock          (clock),
        .reset          (reset),
        .rxd            (rxd),
        .txd            (txd),
        .header_req     (header_req),
        .header_ack     (header_ack),
        .header_data    (header_data),
        .nonce_req      (nonce_req),
        .nonce_ack      (nonce_ack),
        .nonce_data     (nonce_data),
        .display_toggle (display_toggle),
        .ca             (ca),
        .an             (an),
        .error          (error)
    );

    bind uart_core uart_core_props u_props (
        .clock      (clock),
        .reset      (reset),
        .header_req (header_req),
        .header_ack (header_ack),
        .nonce_req  (nonce_req),
        .nonce_ack  (nonce_ack),
        .an         (an),
        .txd        (txd),
        .busy       (tx_busy)
    );

    always #5 clock = ~clock;

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // one 8N1 frame on rxd after a random idle gap
    task automatic send_byte(input logic [7:0] b, input logic bad_stop);
        int gap;
        gap = {$random(seed)} % 24;
        repeat (gap) @(posedge clock);
        rxd <= 1'b0;
        repeat (BIT_CLKS) @(posedge clock);
        for (int i = 0; i < 8; i++) begin
            rxd <= b[i];
            repeat (BIT_CLKS) @(posedge clock);
        end
        rxd <= ~bad_stop;
        repeat (BIT_CLKS) @(posedge clock);
        if (bad_stop) begin
            rxd <= 1'b1;
            repeat (BIT_CLKS) @(posedge clock);
        end
    endtask

    task automatic send_header(input int bad_at);
        logic [31:0] r;
        for (int i = 0; i < HDR_BYTES; i++) begin
            if (i == bad_at) begin
                r = $random(seed);
                send_byte(r[7:0], 1'b1);
                exp_error = 1'b1;
                expect_value("error", 32'(error), 32'h1);
            end
            r = $random(seed);
            hdr_bytes[i] = r[7:0];
            if (i == HDR_BYTES - 1)
                expect_value("header_req", 32'(header_req), 32'h0);
            send_byte(hdr_bytes[i], 1'b0);
        end
    endtask

    task automatic check_header();
        logic [HDR_W-1:0] exp;
        int waited;
        for (int i = 0; i < HDR_BYTES; i++)
            exp[HDR_W-1-8*i -: 8] = hdr_bytes[i]; // first byte on top
        waited = 0;
        while (header_req !== 1'b1 && waited < 2 * FRAME_CLKS) begin
            @(posedge clock);
            waited++;
        end
        assert (header_req === 1'b1) else begin
            $display("header_req did not rise after the last header byte");
            other_errors++;
        end
        assert (header_data === exp) else begin
            $display("** Error header_data: got %h expected %h", header_data, exp);
            value_errors++;
        end
        repeat ({$random(seed)} % 16) @(posedge clock);
        header_ack <= 1'b1;
        waited = 0;
        @(posedge clock);
        while (header_req !== 1'b0 && waited < 4) begin
            @(posedge clock);
            waited++;
        end
        assert (header_req === 1'b0) else begin
            $display("header_req stayed high after header_ack");
            other_errors++;
        end
        header_ack <= 1'b0;
        @(posedge clock);
        expect_value("error", 32'(error), 32'(exp_error));
    endtask

    task automatic nonce_transaction();
        logic [31:0] n;
        logic [7:0]  got;
        int          waited;
        n = $random(seed);
        tx_queue.delete();
        nonce_data <= n;
        nonce_req  <= 1'b1;
        waited = 0;
        while (nonce_ack !== 1'b1 && waited < NONCE_BYTES * (FRAME_CLKS + 8) + 50) begin
            @(posedge clock);
            waited++;
        end
        assert (nonce_ack === 1'b1 && tx_queue.size() == NONCE_BYTES) else begin
            $display("nonce_ack came with %0d bytes on txd", tx_queue.size());
            other_errors++;
        end
        for (int i = 0; i < NONCE_BYTES && tx_queue.size() > 0; i++) begin
            got = tx_queue.pop_front();
            expect_value("txd byte", 32'(got), 32'(n[31-8*i -: 8])); // msb first
        end
        nonce_req <= 1'b0;
        exp_nonce_shown = n;
        waited = 0;
        @(posedge clock);
        while (nonce_ack !== 1'b0 && waited < 4) begin
            @(posedge clock);
            waited++;
        end
        expect_value("nonce_ack", 32'(nonce_ack), 32'h0);
    endtask

    task automatic check_display(input logic toggle);
        logic [31:0] word;
        int          k;
        int          checked;
        display_toggle <= toggle;
        // every digit refresh from here on used the new word
        repeat (`UART_SCAN_DIV) @(posedge clock);
        word = toggle ? {hdr_bytes[0], hdr_bytes[1], hdr_bytes[2], hdr_bytes[3]}
                      : exp_nonce_shown;
        checked = 0;
        repeat (3 * 8 * `UART_SCAN_DIV) begin
            @(posedge clock);
            if (an != 8'hff) begin
                k = 0;
                for (int j = 0; j < 8; j++)
                    if (an[j] == 1'b0)
                        k = j;
                expect_value("ca", 32'(ca), 32'({1'b1, SEG[word[4*k +: 4]]}));
                checked++;
            end
        end
        assert (checked > 0) else begin
            $display("no digit was enabled on an during the display check");
            other_errors++;
        end
    endtask

    // txd decoder, samples at bit centers
    initial begin
        forever begin
            @(posedge clock);
            if (!reset && txd === 1'b0) begin
                repeat (BIT_CLKS / 2) @(posedge clock);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(posedge clock);
                    mon_byte[i] = txd;
                end
                repeat (BIT_CLKS) @(posedge clock);
                assert (txd === 1'b1) else begin
                    $display("stop bit on txd sampled low");
                    stop_errors++;
                end
                tx_queue.push_back(mon_byte);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("value errors: %0d, other errors: %0d", value_errors,
                 other_errors + stop_errors + 1);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clock          = 1'b0;
        reset          <= 1'b1;
        rxd            <= 1'b1;
        header_ack     <= 1'b0;
        nonce_req      <= 1'b0;
        nonce_data     <= '0;
        display_toggle <= 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        expect_value("txd", 32'(txd), 32'h1);
        expect_value("header_req", 32'(header_req), 32'h0);
        expect_value("nonce_ack", 32'(nonce_ack), 32'h0);
        expect_value("error", 32'(error), 32'h0);
        expect_value("ca", 32'(ca), 32'hff);
        expect_value("an", 32'(an), 32'hff);

        send_header(-1);
        check_header();
        nonce_transaction();

        fork
            begin
                send_header(-1);
                check_header();
            end
            begin
                repeat ({$random(seed)} % 200) @(posedge clock);
                nonce_transaction();
            end
        join
        expect_value("error", 32'(error), 32'h0);

        // bad frame somewhere in the header
        send_header({$random(seed)} % HDR_BYTES);
        check_header();

        check_display(1'b1);
        check_display(1'b0);

        prop_errors = DUT.u_props.fail_count;
        $display("value errors: %0d, other errors: %0d", value_errors,
                 other_errors + stop_errors + prop_errors);
        if (value_errors + other_errors + stop_errors + prop_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
